/* compile.f */
hw/seq_pkg.sv
hw/seq_ifs.sv
hw/alu8.sv
hw/insn_fetch.sv
hw/insn_buffer.sv
hw/insn_exec.sv
hw/seq_top.sv
tests/tb_seq.sv

/* Makefile */
TOP := tb_seq

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -j 0 -f compile.f --top-module $(TOP)

run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "No errors"

lint:
	verilator --lint-only --timing -Wall -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir

/* tests/tb_seq.sv */
`timescale 1ns/10ps

module tb_seq;

    localparam logic [15:0] RESET_IP = 16'h0000;

    logic        clk;
    logic        i_rst_n;
    logic [7:0]  i_rdata;
    logic        i_mcycle_done;
    logic [15:0] o_addr;
    logic        o_mem_rd;
    logic        o_mem_wr;
    logic [7:0]  o_wdata;
    logic        o_opcode_fetch;
    logic        o_halted;

    logic [7:0]  mem [0:65535];
    logic [7:0]  ref_mem [0:65535];
    logic [15:0] exp_fetch [$];
    logic        exp_spec [$];
    logic [15:0] exp_next [$];
    logic [15:0] exp_wr_addr [$];
    logic [7:0]  exp_wr_data [$];
    logic [15:0] exp_rd_addr [$];

    integer      seed = 32'hb799;
    int          errors = 0;
    int          fetch_idx = 0;
    int          wr_idx = 0;
    int          rd_idx = 0;
    int          spec_cnt = 0;
    int          rst_cycles = 0;
    logic [15:0] spec_addr;
    logic        model_ready = 1'b0;
    logic        finished = 1'b0;
    logic        first_seen = 1'b0;
    logic        mem_active;
    logic [1:0]  waits;
    logic        rd_q, wr_q, done_q, halted_q;
    logic [15:0] addr_q;
    logic [7:0]  wdata_q;

    seq_top #(
        .RESET_IP (RESET_IP)
    ) i_seq_top (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_rdata        (i_rdata),
        .i_mcycle_done  (i_mcycle_done),
        .o_addr         (o_addr),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_wdata        (o_wdata),
        .o_opcode_fetch (o_opcode_fetch),
        .o_halted       (o_halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        errors++;
        $display("ERR t=%0t %s: got %h expected %h", $time, name, got, exp);
    endtask

    task automatic report_failure(input string what);
        errors++;
        $display("Failure at t=%0t: %s", $time, what);
    endtask

    task automatic put_byte(input logic [15:0] a, input logic [7:0] d);
        mem[a]     = d;
        ref_mem[a] = d;
    endtask

    // Background pattern mixes both address bytes
    task automatic load_program();
        logic [7:0] prog [$];
        // ADD and SUB with stores, a load and store back, XOR to zero for a taken JP Z
        prog = '{8'h06, 8'h05, 8'h0E, 8'h03, 8'h3E, 8'h10, 8'h80,
                 8'h32, 8'h00, 8'h80, 8'h89, 8'h32, 8'h01, 8'h80,
                 8'h3A, 8'h10, 8'h80, 8'h32, 8'h02, 8'h80, 8'h16, 8'h5A,
                 8'h9A, 8'hCA, 8'h20, 8'h00, 8'h76};
        for (int a = 0; a < 65536; a++) begin
            put_byte(16'(a), 8'(a) ^ 8'(a >> 8) ^ 8'h3C);
        end
        foreach (prog[i]) put_byte(RESET_IP + 16'(i), prog[i]);
        // Not-taken JP Z, then an unconditional jump over a HALT
        prog = '{8'h80, 8'hCA, 8'h00, 8'h00, 8'h32, 8'h03, 8'h80, 8'h91,
                 8'hC3, 8'h30, 8'h00, 8'h76};
        foreach (prog[i]) put_byte(RESET_IP + 16'h20 + 16'(i), prog[i]);
        prog = '{8'h32, 8'h04, 8'h80, 8'h00, 8'h76};
        foreach (prog[i]) put_byte(RESET_IP + 16'h30 + 16'(i), prog[i]);
        put_byte(16'h8010, 8'h5A);
    endtask

    // Executes the program from the instruction set rules
    task automatic run_model();
        logic [7:0]  r [8];
        logic [15:0] ip;
        logic [15:0] nn;
        logic [15:0] nxt;
        logic [7:0]  op;
        logic [8:0]  wide;
        logic        z;
        logic        stop;
        int          steps;
        foreach (r[i]) r[i] = 8'h00;
        z = 1'b0;
        ip = RESET_IP;
        stop = 1'b0;
        steps = 0;
        while (!stop && steps < 200) begin
            op = ref_mem[ip];
            nn = {ref_mem[ip + 16'd2], ref_mem[ip + 16'd1]};
            exp_fetch.push_back(ip);
            nxt = ip + 16'd1;
            if ((op & 8'hC7) == 8'h06) begin
                r[op[5:3]] = ref_mem[ip + 16'd1];
                nxt = ip + 16'd2;
            end else if ((op & 8'hE0) == 8'h80) begin
                case (op[4:3])
                    2'd0: wide = {1'b0, r[7]} + {1'b0, r[op[2:0]]};
                    2'd1: wide = {1'b0, r[7]} - {1'b0, r[op[2:0]]};
                    2'd2: wide = {1'b0, r[7] & r[op[2:0]]};
                    default: wide = {1'b0, r[7] ^ r[op[2:0]]};
                endcase
                r[7] = wide[7:0];
                z = (wide[7:0] == 8'h00);
            end else if (op == 8'h3A || op == 8'h32 || op == 8'hC3 || op == 8'hCA) begin
                nxt = ip + 16'd3;
            end
            exp_spec.push_back(op == 8'hC3 || op == 8'hCA || op == 8'h76);
            exp_next.push_back(nxt);
            if (op == 8'h3A) begin
                exp_rd_addr.push_back(nn);
                r[7] = ref_mem[nn];
            end else if (op == 8'h32) begin
                exp_wr_addr.push_back(nn);
                exp_wr_data.push_back(r[7]);
                ref_mem[nn] = r[7];
            end
            if (op == 8'h76) stop = 1'b1;
            else if (op == 8'hC3 || (op == 8'hCA && z)) ip = nn;
            else ip = nxt;
            steps++;
        end
    endtask

    // Memory with 0 to 3 random wait states per bus cycle
    always @(posedge clk) begin
        if (!i_rst_n) begin
            i_mcycle_done <= 1'b0;
            mem_active    <= 1'b0;
        end else if (i_mcycle_done) begin
            i_mcycle_done <= 1'b0;
        end else if (o_mem_rd || o_mem_wr) begin
            if (!mem_active) begin
                mem_active <= 1'b1;
                waits      <= 2'($random(seed));
            end else if (waits == 2'd0) begin
                i_mcycle_done <= 1'b1;
                i_rdata       <= mem[o_addr];
                mem_active    <= 1'b0;
                if (o_mem_wr) mem[o_addr] <= o_wdata;
            end else begin
                waits <= waits - 2'd1;
            end
        end
    end

    // Bus protocol and program order checks
    always @(posedge clk) begin
        logic        in_range;
        logic [15:0] exp_a;
        if (!i_rst_n) begin
            // Bus outputs are known once the first reset clock has passed
            if (rst_cycles > 0) begin
                assert (!o_mem_rd && !o_mem_wr) else report_failure("bus active in reset");
            end
            rst_cycles++;
        end else begin
            assert (!(o_mem_rd && o_mem_wr)) else report_failure("read and write together");
            if ((rd_q || wr_q) && !done_q) begin
                assert (o_mem_rd == rd_q) else report_mismatch("o_mem_rd", o_mem_rd, rd_q);
                assert (o_mem_wr == wr_q) else report_mismatch("o_mem_wr", o_mem_wr, wr_q);
                assert (o_addr == addr_q) else report_mismatch("o_addr", o_addr, addr_q);
                assert (!wr_q || o_wdata == wdata_q)
                    else report_mismatch("o_wdata", o_wdata, wdata_q);
            end
            assert (!(halted_q && !rd_q && !wr_q && (o_mem_rd || o_mem_wr)))
                else report_failure("bus cycle started after halt");
            if (o_mem_rd && !rd_q && !first_seen) begin
                first_seen = 1'b1;
                assert (o_opcode_fetch) else report_failure("first read is no opcode fetch");
                assert (o_addr == RESET_IP) else report_mismatch("o_addr", o_addr, RESET_IP);
            end
            if (o_mem_rd && !rd_q && o_opcode_fetch) begin
                in_range = (fetch_idx < exp_fetch.size());
                exp_a = in_range ? exp_fetch[fetch_idx] : 16'h0000;
                if (in_range && o_addr == exp_a) begin
                    if (spec_cnt > 0) spec_cnt--;
                    if (exp_spec[fetch_idx]) begin
                        spec_cnt  = 2;
                        spec_addr = exp_next[fetch_idx];
                    end
                    fetch_idx++;
                end else begin
                    // Fall-through opcode read in flight when a jump or HALT executes
                    assert (spec_cnt > 0 && o_addr == spec_addr)
                        else report_mismatch("o_addr", o_addr, exp_a);
                    spec_cnt = 0;
                end
            end
            if (o_mem_wr && i_mcycle_done) begin
                if (wr_idx < exp_wr_addr.size()) begin
                    assert (o_addr == exp_wr_addr[wr_idx])
                        else report_mismatch("o_addr", o_addr, exp_wr_addr[wr_idx]);
                    assert (o_wdata == exp_wr_data[wr_idx])
                        else report_mismatch("o_wdata", o_wdata, exp_wr_data[wr_idx]);
                end else begin
                    report_failure("unexpected bus write");
                end
                wr_idx++;
            end
            if (o_mem_rd && i_mcycle_done && o_addr >= 16'h8000) begin
                if (rd_idx < exp_rd_addr.size()) begin
                    assert (o_addr == exp_rd_addr[rd_idx])
                        else report_mismatch("o_addr", o_addr, exp_rd_addr[rd_idx]);
                end else begin
                    report_failure("unexpected data read");
                end
                rd_idx++;
            end
        end
        rd_q     <= o_mem_rd;
        wr_q     <= o_mem_wr;
        done_q   <= i_mcycle_done;
        halted_q <= o_halted;
        addr_q   <= o_addr;
        wdata_q  <= o_wdata;
    end

    initial begin
        i_rst_n       = 1'b0;
        i_rdata       = 8'h00;
        i_mcycle_done = 1'b0;
        load_program();
        run_model();
        model_ready = 1'b1;
        repeat (3) @(posedge clk);
        i_rst_n <= 1'b1;
        wait (o_halted);
        // Quiet period after halt
        repeat (100) @(posedge clk);
        assert (fetch_idx == exp_fetch.size()) else report_failure("opcode fetches missing");
        assert (wr_idx == exp_wr_addr.size()) else report_failure("bus writes missing");
        assert (rd_idx == exp_rd_addr.size()) else report_failure("data reads missing");
        finished = 1'b1;
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // 30 cycles per instruction, times 4 wait states
    initial begin
        wait (model_ready);
        repeat (exp_fetch.size() * 30 * 4) @(posedge clk);
        if (!finished) begin
            errors++;
            $display("Timeout: the program did not reach HALT in time");
            $display("errors: %0d", errors);
            $display("Errors found");
            $finish;
        end
    end

endmodule

/* hw/seq_top.sv */
`timescale 1ns/10ps

module seq_top #(
    parameter seq_pkg::addr_t RESET_IP = '0
) (
    input  logic           clk,
    input  logic           i_rst_n,
    input  seq_pkg::byte_t i_rdata,
    input  logic           i_mcycle_done,
    output seq_pkg::addr_t o_addr,
    output logic           o_mem_rd,
    output logic           o_mem_wr,
    output seq_pkg::byte_t o_wdata,
    output logic           o_opcode_fetch,
    output logic           o_halted
);

    byte_if u_byte_if ();
    insn_if u_insn_if ();
    data_if u_data_if ();

    // Bus master, owns the instruction pointer
    insn_fetch #(
        .RESET_IP (RESET_IP)
    ) u_fetch (
        .clk            (clk),
        .i_rst_n        (i_rst_n),
        .i_rdata        (i_rdata),
        .i_mcycle_done  (i_mcycle_done),
        .i_halted       (o_halted),
        .o_addr         (o_addr),
        .o_mem_rd       (o_mem_rd),
        .o_mem_wr       (o_mem_wr),
        .o_wdata        (o_wdata),
        .o_opcode_fetch (o_opcode_fetch),
        .byte_ch        (u_byte_if.producer),
        .data_ch        (u_data_if.server)
    );

    insn_buffer u_buffer (
        .clk     (clk),
        .i_rst_n (i_rst_n),
        .byte_ch (u_byte_if.receiver),
        .insn_ch (u_insn_if.producer)
    );

    insn_exec u_exec (
        .clk      (clk),
        .i_rst_n  (i_rst_n),
        .insn_ch  (u_insn_if.consumer),
        .data_ch  (u_data_if.client),
        .o_halted (o_halted)
    );

endmodule

/* hw/insn_exec.sv */
`timescale 1ns/10ps

module insn_exec (
    input  logic     clk,
    input  logic     i_rst_n,
    insn_if.consumer insn_ch,
    data_if.client   data_ch,
    output logic     o_halted
);

    typedef enum logic [1:0] {
        RUN,
        WAIT_MEM,
        HALT
    } state_e;

    state_e            state;
    seq_pkg::byte_t    regs [8];
    seq_pkg::flags_t   flags;
    seq_pkg::byte_t    op_bits;
    seq_pkg::reg_idx_t dst_idx;
    seq_pkg::reg_idx_t src_idx;
    logic              fire;
    logic              is_ld_rn;
    logic              is_alu;
    logic              is_mem;
    seq_pkg::alu_op_e  alu_op;
    seq_pkg::byte_t    alu_result;
    seq_pkg::flags_t   alu_flags;

    assign op_bits  = insn_ch.opcode;
    assign dst_idx  = op_bits[5:3];
    assign src_idx  = op_bits[2:0];
    assign is_ld_rn = (op_bits & 8'hC7) == seq_pkg::OP_LD_RN_BASE;
    assign is_alu   = (op_bits & 8'hE0) == seq_pkg::OP_ALU_BASE;
    assign is_mem   = (insn_ch.opcode == seq_pkg::OP_LD_A_MEM) ||
                      (insn_ch.opcode == seq_pkg::OP_LD_MEM_A);
    assign alu_op   = seq_pkg::alu_op_e'(op_bits[4:3]);

    // Only accept in RUN, so a memory access or HALT blocks the next one
    assign insn_ch.ready = (state == RUN);
    assign fire          = insn_ch.valid && insn_ch.ready;
    assign o_halted      = (state == HALT);

    alu8 u_alu (
        .i_op     (alu_op),
        .i_x      (regs[seq_pkg::REG_A]),
        .i_y      (regs[src_idx]),
        .o_result (alu_result),
        .o_flags  (alu_flags)
    );

    // Redirect in the cycle of acceptance
    // JP Z not taken still redirects, to the following instruction
    always_comb begin
        data_ch.jump   = 1'b0;
        data_ch.target = insn_ch.next_ip;
        if (fire) begin
            if (insn_ch.opcode == seq_pkg::OP_JP) begin
                data_ch.jump   = 1'b1;
                data_ch.target = insn_ch.operand;
            end else if (insn_ch.opcode == seq_pkg::OP_JP_Z) begin
                data_ch.jump   = 1'b1;
                data_ch.target = flags.zero ? insn_ch.operand : insn_ch.next_ip;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state       <= RUN;
            flags       <= '0;
            data_ch.req <= 1'b0;
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else begin
            case (state)
                RUN: begin
                    if (fire) begin
                        if (is_ld_rn) begin
                            regs[dst_idx] <= insn_ch.operand[7:0];
                        end else if (is_alu) begin
                            regs[seq_pkg::REG_A] <= alu_result;
                            flags                <= alu_flags;
                        end else if (is_mem) begin
                            data_ch.req <= 1'b1;
                            state       <= WAIT_MEM;
                        end else if (insn_ch.opcode == seq_pkg::OP_HALT) begin
                            state <= HALT;
                        end
                    end
                end
                WAIT_MEM: begin
                    if (data_ch.done) begin
                        data_ch.req <= 1'b0;
                        state       <= RUN;
                        if (!data_ch.wr) begin
                            regs[seq_pkg::REG_A] <= data_ch.rdata;
                        end
                    end
                end
                // Only reset leaves HALT
                default: state <= HALT;
            endcase
        end
    end

    // Request address and store data, captured on acceptance
    always_ff @(posedge clk) begin
        if (fire) begin
            data_ch.wr    <= (insn_ch.opcode == seq_pkg::OP_LD_MEM_A);
            data_ch.addr  <= insn_ch.operand;
            data_ch.wdata <= regs[seq_pkg::REG_A];
        end
    end

endmodule

/* hw/insn_buffer.sv */
`timescale 1ns/10ps

module insn_buffer (
    input  logic     clk,
    input  logic     i_rst_n,
    byte_if.receiver byte_ch,
    insn_if.producer insn_ch
);

    logic [1:0]     count;
    logic           full;
    seq_pkg::byte_t opcode_q;
    logic [15:0]    operand_q;
    seq_pkg::addr_t next_ip_q;
    logic [1:0]     need;
    logic           take;
    logic           last;

    // Instruction length in bytes, from the opcode alone
    function automatic logic [1:0] insn_len(input seq_pkg::byte_t op);
        logic [1:0] len;
        len = 2'd1;
        if ((op & 8'hC7) == seq_pkg::OP_LD_RN_BASE) begin
            len = 2'd2;
        end else begin
            case (op)
                seq_pkg::OP_LD_A_MEM,
                seq_pkg::OP_LD_MEM_A,
                seq_pkg::OP_JP,
                seq_pkg::OP_JP_Z: len = 2'd3;
                default:          len = 2'd1;
            endcase
        end
        return len;
    endfunction

    // The opcode is still on the byte bus when nothing is collected yet
    assign need = insn_len((count == 2'd0) ? byte_ch.data : opcode_q);
    assign take = byte_ch.valid && byte_ch.ready;
    assign last = (2'(count + 2'd1) == need);

    assign byte_ch.ready = !full;
    // Tells fetch whether its next read starts a new instruction
    assign byte_ch.first = byte_ch.valid ? last : (count == 2'd0);

    assign insn_ch.valid   = full;
    assign insn_ch.opcode  = seq_pkg::opcode_e'(opcode_q);
    assign insn_ch.operand = operand_q;
    assign insn_ch.len     = count;
    assign insn_ch.next_ip = next_ip_q;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            count <= 2'd0;
            full  <= 1'b0;
        end else if (byte_ch.flush || (full && insn_ch.ready)) begin
            count <= 2'd0;
            full  <= 1'b0;
        end else if (take) begin
            count <= count + 2'd1;
            full  <= last;
        end
    end

    // Byte assembly, little-endian operand
    always_ff @(posedge clk) begin
        if (take) begin
            next_ip_q <= byte_ch.addr + 1'b1;
            case (count)
                2'd0: begin
                    opcode_q  <= byte_ch.data;
                    operand_q <= '0;
                end
                2'd1:    operand_q[7:0]  <= byte_ch.data;
                default: operand_q[15:8] <= byte_ch.data;
            endcase
        end
    end

endmodule

/* hw/insn_fetch.sv */
`timescale 1ns/10ps

module insn_fetch #(
    parameter seq_pkg::addr_t RESET_IP = '0
) (
    input  logic           clk,
    input  logic           i_rst_n,
    input  seq_pkg::byte_t i_rdata,
    input  logic           i_mcycle_done,
    input  logic           i_halted,
    output seq_pkg::addr_t o_addr,
    output logic           o_mem_rd,
    output logic           o_mem_wr,
    output seq_pkg::byte_t o_wdata,
    output logic           o_opcode_fetch,
    byte_if.producer       byte_ch,
    data_if.server         data_ch
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        DATA_RD,
        DATA_WR
    } state_e;

    state_e         state;
    seq_pkg::addr_t ip;
    logic           drop;
    logic           byte_valid;
    seq_pkg::byte_t byte_data;
    seq_pkg::addr_t byte_addr;
    logic           cycle_end;
    logic           start_data;
    logic           start_fetch;

    // Current bus cycle completes in this clock
    assign cycle_end = (state != IDLE) && i_mcycle_done;

    // Data requests win when the bus is free
    assign start_data  = (state == IDLE) && data_ch.req;
    // No new fetch on a redirect, while halted or while the buffer is full
    assign start_fetch = (state == IDLE) && !data_ch.req && !data_ch.jump &&
                         !i_halted && byte_ch.ready;

    assign byte_ch.valid = byte_valid;
    assign byte_ch.data  = byte_data;
    assign byte_ch.addr  = byte_addr;
    assign byte_ch.flush = data_ch.jump;

    // Data cycles finish straight off the memory handshake
    assign data_ch.done  = cycle_end && (state != FETCH);
    assign data_ch.rdata = i_rdata;

    always_ff @(posedge clk) begin
        if (!i_rst_n) begin
            state          <= IDLE;
            ip             <= RESET_IP;
            drop           <= 1'b0;
            byte_valid     <= 1'b0;
            o_mem_rd       <= 1'b0;
            o_mem_wr       <= 1'b0;
            o_opcode_fetch <= 1'b0;
        end else begin
            // Byte slot empties on transfer or flush
            if ((byte_valid && byte_ch.ready) || data_ch.jump) begin
                byte_valid <= 1'b0;
            end

            case (state)
                IDLE: begin
                    if (start_data) begin
                        state    <= data_ch.wr ? DATA_WR : DATA_RD;
                        o_mem_rd <= !data_ch.wr;
                        o_mem_wr <= data_ch.wr;
                    end else if (start_fetch) begin
                        state          <= FETCH;
                        ip             <= ip + 1'b1;
                        o_mem_rd       <= 1'b1;
                        o_opcode_fetch <= byte_ch.first;
                    end
                end
                FETCH: begin
                    if (i_mcycle_done) begin
                        state          <= IDLE;
                        o_mem_rd       <= 1'b0;
                        o_opcode_fetch <= 1'b0;
                        // A byte read past a taken redirect is thrown away
                        byte_valid     <= !drop && !data_ch.jump;
                        drop           <= 1'b0;
                    end else if (data_ch.jump) begin
                        drop <= 1'b1;
                    end
                end
                default: begin
                    if (i_mcycle_done) begin
                        state    <= IDLE;
                        o_mem_rd <= 1'b0;
                        o_mem_wr <= 1'b0;
                    end
                end
            endcase

            if (data_ch.jump) begin
                ip <= data_ch.target;
            end
        end
    end

    // Bus address and data, plus the captured instruction byte
    always_ff @(posedge clk) begin
        if (start_data) begin
            o_addr  <= data_ch.addr;
            o_wdata <= data_ch.wdata;
        end else if (start_fetch) begin
            o_addr <= ip;
        end

        if (state == FETCH && i_mcycle_done) begin
            byte_data <= i_rdata;
            byte_addr <= o_addr;
        end
    end

endmodule

/* hw/alu8.sv */
`timescale 1ns/10ps

module alu8 (
    input  seq_pkg::alu_op_e i_op,
    input  seq_pkg::byte_t   i_x,
    input  seq_pkg::byte_t   i_y,
    output seq_pkg::byte_t   o_result,
    output seq_pkg::flags_t  o_flags
);

    // Bit 8 holds the carry out or the borrow
    logic [8:0] wide;

    always_comb begin
        case (i_op)
            seq_pkg::ALU_ADD: wide = {1'b0, i_x} + {1'b0, i_y};
            seq_pkg::ALU_SUB: wide = {1'b0, i_x} - {1'b0, i_y};
            seq_pkg::ALU_AND: wide = {1'b0, i_x & i_y};
            default:          wide = {1'b0, i_x ^ i_y};
        endcase
    end

    assign o_result      = wide[7:0];
    // Logic operations leave bit 8 clear
    assign o_flags.carry = wide[8];
    assign o_flags.zero  = (wide[7:0] == 8'h00);

endmodule

/* hw/seq_ifs.sv */
`timescale 1ns/10ps

// Instruction bytes from fetch to the buffer
// addr is the memory address the byte was read from
interface byte_if;
    logic           valid;
    seq_pkg::byte_t data;
    seq_pkg::addr_t addr;
    logic           first;
    logic           flush;
    logic           ready;

    modport producer (
        output valid, data, addr, flush,
        input  first, ready
    );

    modport receiver (
        input  valid, data, addr, flush,
        output first, ready
    );
endinterface

// One assembled instruction from the buffer to the executor
interface insn_if;
    logic             valid;
    seq_pkg::opcode_e opcode;
    // Little-endian, low byte first
    logic [15:0]      operand;
    logic [1:0]       len;
    seq_pkg::addr_t   next_ip;
    logic             ready;

    modport producer (
        output valid, opcode, operand, len, next_ip,
        input  ready
    );

    modport consumer (
        input  valid, opcode, operand, len, next_ip,
        output ready
    );
endinterface

// Data accesses and redirects from the executor to fetch
interface data_if;
    logic           req;
    logic           wr;
    seq_pkg::addr_t addr;
    seq_pkg::byte_t wdata;
    logic           done;
    seq_pkg::byte_t rdata;
    logic           jump;
    seq_pkg::addr_t target;

    modport client (
        output req, wr, addr, wdata, jump, target,
        input  done, rdata
    );

    modport server (
        input  req, wr, addr, wdata, jump, target,
        output done, rdata
    );
endinterface

/* hw/seq_pkg.sv */
package seq_pkg;

    // Memory address width of the external bus
    localparam int ADDR_W = 16;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [7:0]        byte_t;

    // Index into the eight-entry register file
    typedef logic [2:0] reg_idx_t;

    // Accumulator sits at the top of the register file
    localparam reg_idx_t REG_A = 3'd7;

    // Recognised opcodes
    // The BASE entries are patterns with register or operation fields
    // LD r,n   is 00 rrr 110
    // ALU A,r  is 100 oo rrr, with oo picking the ALU operation
    typedef enum logic [7:0] {
        OP_NOP        = 8'h00,
        OP_LD_RN_BASE = 8'h06,
        OP_LD_MEM_A   = 8'h32,
        OP_LD_A_MEM   = 8'h3A,
        OP_HALT       = 8'h76,
        OP_ALU_BASE   = 8'h80,
        OP_JP         = 8'hC3,
        OP_JP_Z       = 8'hCA
    } opcode_e;

    // ALU operation, taken from opcode bits 4:3
    typedef enum logic [1:0] {
        ALU_ADD = 2'd0,
        ALU_SUB = 2'd1,
        ALU_AND = 2'd2,
        ALU_XOR = 2'd3
    } alu_op_e;

    typedef struct packed {
        logic zero;
        logic carry;
    } flags_t;

endpackage
